//--- compile.f
+incdir+src
src/axi_rd_pkg.sv
src/ar_arbiter.sv
src/rd_mem_slave.sv
src/r_router.sv
src/axi_rd_top.sv
bench/axi_rd_chk.sv
bench/axi_rd_tb.sv

//--- Makefile
# Verilator build and run of the AXI read testbench

VERILATOR ?= verilator
TOP       ?= axi_rd_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/axi_rd_tb.sv
`default_nettype none

`include "axi_rd_settings.svh"

module axi_rd_tb;

	localparam int NROWS = 7;

	typedef struct packed {
		logic                if_v;
		axi_rd_pkg::ar_req_t if_req;
		logic                mem_v;
		axi_rd_pkg::ar_req_t mem_req;
		logic                stall;   // random r_ready on both requesters
	} row_t;

	logic                clk;
	logic                reset;
	axi_rd_pkg::ar_req_t if_ar;
	logic                if_ar_valid;
	logic                if_ar_ready;
	axi_rd_pkg::r_beat_t if_r;
	logic                if_r_valid;
	logic                if_r_ready;
	axi_rd_pkg::ar_req_t mem_ar;
	logic                mem_ar_valid;
	logic                mem_ar_ready;
	axi_rd_pkg::r_beat_t mem_r;
	logic                mem_r_valid;
	logic                mem_r_ready;
	logic                mem_wr_valid;
	axi_rd_pkg::mem_wr_t mem_wr;

	logic [`AXI_RD_DATA_W-1:0] model [`AXI_RD_MEM_WORDS];  // reference copy of the preload
	axi_rd_pkg::r_beat_t       if_exp[$];
	axi_rd_pkg::r_beat_t       mem_exp[$];
	axi_rd_pkg::owner_e        grant_q[$];   // expected order of address grants
	row_t                      rows [NROWS];
	logic [31:0]               rng;
	logic                      stall;
	logic                      mon_en;
	logic                      running;
	logic                      burst_open;
	logic                      if_first;     // first fetch beat due this cycle
	logic                      mem_first;
	int                        cycles;
	int                        limit;

	axi_rd_top uut (
		.clk          (clk),
		.reset        (reset),
		.if_ar        (if_ar),
		.if_ar_valid  (if_ar_valid),
		.if_ar_ready  (if_ar_ready),
		.if_r         (if_r),
		.if_r_valid   (if_r_valid),
		.if_r_ready   (if_r_ready),
		.mem_ar       (mem_ar),
		.mem_ar_valid (mem_ar_valid),
		.mem_ar_ready (mem_ar_ready),
		.mem_r        (mem_r),
		.mem_r_valid  (mem_r_valid),
		.mem_r_ready  (mem_r_ready),
		.mem_wr_valid (mem_wr_valid),
		.mem_wr       (mem_wr)
	);

	bind axi_rd_top axi_rd_chk u_chk (
		.clk          (clk),
		.reset        (reset),
		.if_ar_valid  (if_ar_valid),
		.if_ar_ready  (if_ar_ready),
		.mem_ar_valid (mem_ar_valid),
		.mem_ar_ready (mem_ar_ready),
		.if_r_valid   (if_r_valid),
		.mem_r_valid  (mem_r_valid),
		.slv_ar       (slv_ar),
		.slv_ar_valid (slv_ar_valid),
		.slv_ar_ready (slv_ar_ready),
		.slv_r        (slv_r),
		.slv_r_valid  (slv_r_valid),
		.slv_r_ready  (slv_r_ready)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic end_with_failure(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			end_with_failure($sformatf("mismatch at %0t: %s got %b expected %b",
				$time, name, got, exp));
		end
	endtask

	task automatic check_beat(input string name, input axi_rd_pkg::r_beat_t got,
			input axi_rd_pkg::r_beat_t exp);
		if (got.data !== exp.data) begin
			end_with_failure($sformatf("mismatch at %0t: %s.data got %h expected %h",
				$time, name, got.data, exp.data));
		end else if (got.addr !== exp.addr) begin
			end_with_failure($sformatf("mismatch at %0t: %s.addr got %h expected %h",
				$time, name, got.addr, exp.addr));
		end else if (got.resp !== exp.resp) begin
			end_with_failure($sformatf("mismatch at %0t: %s.resp got %0d expected %0d",
				$time, name, got.resp, exp.resp));
		end else if (got.last !== exp.last) begin
			end_with_failure($sformatf("mismatch at %0t: %s.last got %b expected %b",
				$time, name, got.last, exp.last));
		end
	endtask

	task automatic check_owner(input string name, input axi_rd_pkg::owner_e got,
			input axi_rd_pkg::owner_e exp);
		if (got !== exp) begin
			end_with_failure($sformatf("mismatch at %0t: %s got %s expected %s",
				$time, name, got.name(), exp.name()));
		end
	endtask

	// beats of one burst from the address rules and the model copy
	function automatic void push_burst(input logic to_mem, input axi_rd_pkg::ar_req_t req);
		axi_rd_pkg::r_beat_t b;
		logic [31:0]         a;
		logic [31:0]         w;
		a = req.addr;
		for (int k = 0; k <= int'(req.len); k++) begin
			w = a >> 3;
			b.addr = a;
			b.last = (k == int'(req.len));
			if (w < `AXI_RD_MEM_WORDS) begin
				b.data = model[w[7:0]];
				b.resp = `AXI_RD_RESP_OKAY;
			end else begin
				b.data = '0;
				b.resp = `AXI_RD_RESP_SLVERR;
			end
			if (to_mem) begin
				mem_exp.push_back(b);
			end else begin
				if_exp.push_back(b);
			end
			a = a + (32'd1 << req.size);
		end
	endfunction

	task automatic note_grant(input axi_rd_pkg::owner_e who);
		if (burst_open) begin
			end_with_failure("an address was accepted while a burst was still open");
		end else if (grant_q.size() == 0) begin
			end_with_failure("an address was accepted with no request expected");
		end else begin
			check_owner("grant", who, grant_q.pop_front());
			burst_open = 1'b1;
			if (who == axi_rd_pkg::own_mem) begin
				mem_first = 1'b1;
			end else begin
				if_first = 1'b1;
			end
		end
	endtask

	task automatic apply_row(input row_t rw);
		logic if_pend;
		logic mem_pend;
		if_pend  = rw.if_v;
		mem_pend = rw.mem_v;
		stall    = rw.stall;
		if (rw.mem_v) begin  // mem wins the tie, so it is granted first
			push_burst(1'b1, rw.mem_req);
			grant_q.push_back(axi_rd_pkg::own_mem);
		end
		if (rw.if_v) begin
			push_burst(1'b0, rw.if_req);
			grant_q.push_back(axi_rd_pkg::own_fetch);
		end
		@(posedge clk);
		#1;
		if_ar        = rw.if_req;
		if_ar_valid  = rw.if_v;
		mem_ar       = rw.mem_req;
		mem_ar_valid = rw.mem_v;
		while (if_pend || mem_pend) begin
			@(negedge clk);
			if (if_ar_ready) if_pend = 1'b0;
			if (mem_ar_ready) mem_pend = 1'b0;
			@(posedge clk);
			#1;
			if (!if_pend) if_ar_valid = 1'b0;
			if (!mem_pend) mem_ar_valid = 1'b0;
		end
		while (if_exp.size() != 0 || mem_exp.size() != 0) begin
			@(posedge clk);
		end
		stall = 1'b0;
	endtask

	// r_ready, random only on stall rows
	always @(posedge clk) begin
		#1;
		if (stall) begin
			rng = xorshift(rng);
			if_r_ready  = rng[0];
			mem_r_ready = rng[7];
		end else begin
			if_r_ready  = 1'b1;
			mem_r_ready = 1'b1;
		end
	end

	// outputs sampled mid-cycle
	always @(negedge clk) begin
		if (mon_en) begin
			if (uut.u_chk.fails != 0) begin
				end_with_failure("a protocol assertion in the bound checker failed");
			end
			if (!if_ar_valid && !mem_ar_valid) begin
				check_flag("if_ar_ready", if_ar_ready, 1'b0);
				check_flag("mem_ar_ready", mem_ar_ready, 1'b0);
			end
			if (!running) begin
				check_flag("if_r_valid", if_r_valid, 1'b0);
				check_flag("mem_r_valid", mem_r_valid, 1'b0);
			end
			if (if_first) check_flag("if_r_valid", if_r_valid, 1'b1);
			if (mem_first) check_flag("mem_r_valid", mem_r_valid, 1'b1);
			if_first  = 1'b0;
			mem_first = 1'b0;
			if (if_r_valid && if_r_ready) begin
				if (if_exp.size() == 0) begin
					end_with_failure("a fetch beat arrived with none expected");
				end else begin
					check_beat("if_r", if_r, if_exp.pop_front());
					if (if_r.last) burst_open = 1'b0;
				end
			end
			if (mem_r_valid && mem_r_ready) begin
				if (mem_exp.size() == 0) begin
					end_with_failure("a load/store beat arrived with none expected");
				end else begin
					check_beat("mem_r", mem_r, mem_exp.pop_front());
					if (mem_r.last) burst_open = 1'b0;
				end
			end
			if (if_ar_valid && if_ar_ready && mem_ar_valid && mem_ar_ready) begin
				end_with_failure("both requesters were granted in the same cycle");
			end else if (mem_ar_valid && mem_ar_ready) begin
				note_grant(axi_rd_pkg::own_mem);
			end else if (if_ar_valid && if_ar_ready) begin
				note_grant(axi_rd_pkg::own_fetch);
			end
		end
	end

	always @(posedge clk) begin
		if (running) begin
			cycles = cycles + 1;
			if (cycles > limit) begin
				end_with_failure($sformatf("timeout, the table did not finish in %0d cycles",
					limit));
			end
		end
	end

	initial begin
		clk          = 1'b0;
		reset        = 1'b1;
		if_ar        = '0;
		if_ar_valid  = 1'b0;
		if_r_ready   = 1'b1;
		mem_ar       = '0;
		mem_ar_valid = 1'b0;
		mem_r_ready  = 1'b1;
		mem_wr_valid = 1'b0;
		mem_wr       = '0;
		rng          = 32'ha21c_8bc0;
		stall        = 1'b0;
		mon_en       = 1'b0;
		running      = 1'b0;
		burst_open   = 1'b0;
		if_first     = 1'b0;
		mem_first    = 1'b0;
		cycles       = 0;

		// fetch valid/addr/len/size, mem valid/addr/len/size, stall
		rows[0] = '{1'b1, '{32'h0000_0040, 8'd0, 2'd3}, 1'b0, '{32'h0, 8'd0, 2'd3}, 1'b0};
		rows[1] = '{1'b0, '{32'h0, 8'd0, 2'd3}, 1'b1, '{32'h0000_0100, 8'd7, 2'd3}, 1'b0};
		rows[2] = '{1'b1, '{32'h0000_0200, 8'd3, 2'd3}, 1'b1, '{32'h0000_0300, 8'd2, 2'd3}, 1'b0};
		rows[3] = '{1'b1, '{32'h0000_0010, 8'd5, 2'd3}, 1'b1, '{32'h0000_0500, 8'd7, 2'd3}, 1'b1};
		rows[4] = '{1'b0, '{32'h0, 8'd0, 2'd3}, 1'b1, '{32'h0000_07e0, 8'd5, 2'd3}, 1'b0};
		rows[5] = '{1'b1, '{32'h0000_07f8, 8'd3, 2'd2}, 1'b0, '{32'h0, 8'd0, 2'd3}, 1'b1};
		rows[6] = '{1'b0, '{32'h0, 8'd0, 2'd3}, 1'b1, '{32'h0000_0022, 8'd4, 2'd1}, 1'b0};

		limit = 100;
		for (int i = 0; i < NROWS; i++) begin
			if (rows[i].if_v) limit = limit + (int'(rows[i].if_req.len) + 1) * 8;
			if (rows[i].mem_v) limit = limit + (int'(rows[i].mem_req.len) + 1) * 8;
		end

		repeat (2) @(posedge clk);
		#1;
		reset  = 1'b0;
		mon_en = 1'b1;

		for (int i = 0; i < `AXI_RD_MEM_WORDS; i++) begin
			rng = xorshift(rng);
			model[i][63:32] = rng;
			rng = xorshift(rng);
			model[i][31:0] = rng;
			mem_wr_valid = 1'b1;
			mem_wr.addr  = i[7:0];
			mem_wr.data  = model[i];
			@(posedge clk);
			#1;
		end
		mem_wr_valid = 1'b0;

		running = 1'b1;
		for (int i = 0; i < NROWS; i++) begin
			apply_row(rows[i]);
		end
		running = 1'b0;
		@(posedge clk);

		if (if_exp.size() == 0 && mem_exp.size() == 0 && grant_q.size() == 0
				&& uut.u_chk.fails == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			end_with_failure("beats or grants were left over, or a protocol assertion failed");
		end
	end

endmodule

`default_nettype wire

//--- bench/axi_rd_chk.sv
`default_nettype none

`include "axi_rd_settings.svh"

module axi_rd_chk (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 if_ar_valid,
	input  logic                 if_ar_ready,
	input  logic                 mem_ar_valid,
	input  logic                 mem_ar_ready,
	input  logic                 if_r_valid,
	input  logic                 mem_r_valid,
	input  axi_rd_pkg::ar_req_t  slv_ar,
	input  logic                 slv_ar_valid,
	input  logic                 slv_ar_ready,
	input  axi_rd_pkg::r_beat_t  slv_r,
	input  logic                 slv_r_valid,
	input  logic                 slv_r_ready
);

	logic                     open;        // between address handshake and last beat
	logic                     won_mem;     // load/store won the latest address
	logic [`AXI_RD_LEN_W-1:0] beats_left;  // beats due after the current one
	logic                     beat_fire;
	logic                     final_fire;  // beat that the burst length makes the last
	int                       fails = 0;

	assign beat_fire  = slv_r_valid && slv_r_ready;
	assign final_fire = beat_fire && (beats_left == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			open       <= 1'b0;
			beats_left <= '0;
		end else if (slv_ar_valid && slv_ar_ready) begin
			open       <= 1'b1;
			beats_left <= slv_ar.len;
		end else if (final_fire) begin
			open <= 1'b0;
		end else if (beat_fire) begin
			beats_left <= beats_left - 1'b1;
		end
	end

	// winner seen at the requester ports
	always_ff @(posedge clk) begin
		if (reset) begin
			won_mem <= 1'b0;
		end else if (mem_ar_valid && mem_ar_ready) begin
			won_mem <= 1'b1;
		end else if (if_ar_valid && if_ar_ready) begin
			won_mem <= 1'b0;
		end
	end

	a_one_receiver: assert property (@(posedge clk) disable iff (reset)
		slv_r_valid |-> (won_mem ? (mem_r_valid && !if_r_valid)
			: (if_r_valid && !mem_r_valid)))
		else begin
			fails++;
			$error("a beat went to a requester that did not win the address");
		end

	a_beat_held: assert property (@(posedge clk) disable iff (reset)
		(slv_r_valid && !slv_r_ready) |=> (slv_r_valid && $stable(slv_r)))
		else begin
			fails++;
			$error("stalled beat changed before it was accepted");
		end

	a_no_overlap: assert property (@(posedge clk) disable iff (reset)
		(open && !final_fire) |-> !slv_ar_valid)
		else begin
			fails++;
			$error("address presented while a burst is open");
		end

endmodule

`default_nettype wire

//--- src/axi_rd_top.sv
`default_nettype none

module axi_rd_top (
	input  logic                 clk,
	input  logic                 reset,

	// instruction fetch
	input  axi_rd_pkg::ar_req_t  if_ar,
	input  logic                 if_ar_valid,
	output logic                 if_ar_ready,
	output axi_rd_pkg::r_beat_t  if_r,
	output logic                 if_r_valid,
	input  logic                 if_r_ready,

	// load/store
	input  axi_rd_pkg::ar_req_t  mem_ar,
	input  logic                 mem_ar_valid,
	output logic                 mem_ar_ready,
	output axi_rd_pkg::r_beat_t  mem_r,
	output logic                 mem_r_valid,
	input  logic                 mem_r_ready,

	// backdoor preload
	input  logic                 mem_wr_valid,
	input  axi_rd_pkg::mem_wr_t  mem_wr
);

	axi_rd_pkg::ar_req_t slv_ar;
	logic                slv_ar_valid;
	logic                slv_ar_ready;
	axi_rd_pkg::r_beat_t slv_r;
	logic                slv_r_valid;
	logic                slv_r_ready;
	logic                burst_done;
	axi_rd_pkg::owner_e  owner;

	ar_arbiter u_arbiter (
		.clk          (clk),
		.reset        (reset),
		.if_ar        (if_ar),
		.if_ar_valid  (if_ar_valid),
		.if_ar_ready  (if_ar_ready),
		.mem_ar       (mem_ar),
		.mem_ar_valid (mem_ar_valid),
		.mem_ar_ready (mem_ar_ready),
		.slv_ar       (slv_ar),
		.slv_ar_valid (slv_ar_valid),
		.slv_ar_ready (slv_ar_ready),
		.burst_done   (burst_done),
		.owner        (owner)
	);

	rd_mem_slave u_slave (
		.clk      (clk),
		.reset    (reset),
		.ar       (slv_ar),
		.ar_valid (slv_ar_valid),
		.ar_ready (slv_ar_ready),
		.r        (slv_r),
		.r_valid  (slv_r_valid),
		.r_ready  (slv_r_ready),
		.wr_valid (mem_wr_valid),
		.wr       (mem_wr)
	);

	r_router u_router (
		.owner       (owner),
		.r           (slv_r),
		.r_valid     (slv_r_valid),
		.r_ready     (slv_r_ready),
		.if_r        (if_r),
		.if_r_valid  (if_r_valid),
		.if_r_ready  (if_r_ready),
		.mem_r       (mem_r),
		.mem_r_valid (mem_r_valid),
		.mem_r_ready (mem_r_ready),
		.burst_done  (burst_done)
	);

endmodule

`default_nettype wire

//--- src/r_router.sv
`default_nettype none

module r_router (
	input  axi_rd_pkg::owner_e   owner,

	input  axi_rd_pkg::r_beat_t  r,
	input  logic                 r_valid,
	output logic                 r_ready,

	output axi_rd_pkg::r_beat_t  if_r,
	output logic                 if_r_valid,
	input  logic                 if_r_ready,

	output axi_rd_pkg::r_beat_t  mem_r,
	output logic                 mem_r_valid,
	input  logic                 mem_r_ready,

	output logic                 burst_done
);

	// beats go to the owner only, the other side sees zeros
	always_comb begin
		if (owner == axi_rd_pkg::own_mem) begin
			mem_r       = r;
			mem_r_valid = r_valid;
			if_r        = '0;
			if_r_valid  = 1'b0;
			r_ready     = mem_r_ready;
		end else begin
			if_r        = r;
			if_r_valid  = r_valid;
			mem_r       = '0;
			mem_r_valid = 1'b0;
			r_ready     = if_r_ready;
		end
	end

	// last beat handshake releases the arbiter
	assign burst_done = r_valid && r_ready && r.last;

endmodule

`default_nettype wire

//--- src/rd_mem_slave.sv
`default_nettype none

`include "axi_rd_settings.svh"

module rd_mem_slave (
	input  logic                 clk,
	input  logic                 reset,

	input  axi_rd_pkg::ar_req_t  ar,
	input  logic                 ar_valid,
	output logic                 ar_ready,

	output axi_rd_pkg::r_beat_t  r,
	output logic                 r_valid,
	input  logic                 r_ready,

	input  logic                 wr_valid,
	input  axi_rd_pkg::mem_wr_t  wr
);

	localparam int IDX_W = $clog2(`AXI_RD_MEM_WORDS);

	logic [`AXI_RD_DATA_W-1:0] mem [`AXI_RD_MEM_WORDS];

	logic                      ar_fire;
	logic                      r_fire;
	logic                      load_beat;   // a new beat goes out next cycle
	logic                      beat_last;
	logic                      in_range;
	logic [`AXI_RD_ADDR_W-1:0] beat_addr;
	logic [`AXI_RD_ADDR_W-1:0] step;
	logic [`AXI_RD_ADDR_W-4:0] word;        // beat address over 8
	logic [`AXI_RD_ADDR_W-1:0] addr_q;      // address of the following beat
	logic [`AXI_RD_LEN_W-1:0]  cnt;         // beats left after the current one
	logic [1:0]                size_q;

	// idle whenever no beat is out
	assign ar_ready = !r_valid;

	assign ar_fire = ar_valid && ar_ready;
	assign r_fire  = r_valid && r_ready;
	assign load_beat = ar_fire || (r_fire && !r.last);

	always_comb begin
		if (ar_fire) begin
			beat_addr = ar.addr;
			beat_last = (ar.len == '0);
			step      = `AXI_RD_ADDR_W'(1) << ar.size;
		end else begin
			beat_addr = addr_q;
			beat_last = (cnt == `AXI_RD_LEN_W'(1));
			step      = `AXI_RD_ADDR_W'(1) << size_q;
		end
	end

	assign word = beat_addr[`AXI_RD_ADDR_W-1:3];
	assign in_range = (word < `AXI_RD_MEM_WORDS);

	// boot loader preload
	always_ff @(posedge clk) begin
		if (wr_valid) begin
			mem[wr.addr] <= wr.data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			r_valid <= 1'b0;
			cnt     <= '0;
		end else if (ar_fire) begin
			r_valid <= 1'b1;
			cnt     <= ar.len;
		end else if (r_fire) begin
			if (r.last) begin
				r_valid <= 1'b0;  // burst closed
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	// beat payload, held while r_ready is low
	always_ff @(posedge clk) begin
		if (load_beat) begin
			r.addr <= beat_addr;
			r.last <= beat_last;
			if (in_range) begin
				r.data <= mem[word[IDX_W-1:0]];
				r.resp <= `AXI_RD_RESP_OKAY;
			end else begin
				r.data <= '0;
				r.resp <= `AXI_RD_RESP_SLVERR;
			end
			addr_q <= beat_addr + step;
		end
		if (ar_fire) begin
			size_q <= ar.size;
		end
	end

endmodule

`default_nettype wire

//--- src/ar_arbiter.sv
`default_nettype none

module ar_arbiter (
	input  logic                 clk,
	input  logic                 reset,

	input  axi_rd_pkg::ar_req_t  if_ar,
	input  logic                 if_ar_valid,
	output logic                 if_ar_ready,

	input  axi_rd_pkg::ar_req_t  mem_ar,
	input  logic                 mem_ar_valid,
	output logic                 mem_ar_ready,

	output axi_rd_pkg::ar_req_t  slv_ar,
	output logic                 slv_ar_valid,
	input  logic                 slv_ar_ready,

	input  logic                 burst_done,
	output axi_rd_pkg::owner_e   owner
);

	logic               busy;       // a burst is open
	logic               ch_free;    // channel may take a new request this cycle
	logic               sel_valid;
	logic               ar_fire;
	axi_rd_pkg::owner_e sel;
	axi_rd_pkg::owner_e owner_q;

	// load/store has priority over fetch
	always_comb begin
		if (mem_ar_valid) begin
			sel = axi_rd_pkg::own_mem;
		end else begin
			sel = axi_rd_pkg::own_fetch;
		end
	end

	// the last beat frees the channel in the same cycle
	assign ch_free = !busy || burst_done;

	always_comb begin
		case (sel)
			axi_rd_pkg::own_mem: begin
				slv_ar    = mem_ar;
				sel_valid = mem_ar_valid;
			end
			default: begin
				slv_ar    = if_ar;
				sel_valid = if_ar_valid;
			end
		endcase
	end

	assign slv_ar_valid = ch_free && sel_valid;
	assign ar_fire = slv_ar_valid && slv_ar_ready;

	// ready only back to the chosen requester
	always_comb begin
		if_ar_ready  = 1'b0;
		mem_ar_ready = 1'b0;
		if (slv_ar_valid && slv_ar_ready) begin
			if (sel == axi_rd_pkg::own_mem) begin
				mem_ar_ready = 1'b1;
			end else begin
				if_ar_ready = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy    <= 1'b0;
			owner_q <= axi_rd_pkg::own_fetch;
		end else if (ar_fire) begin
			busy    <= 1'b1;
			owner_q <= sel;  // held until the last beat
		end else if (burst_done) begin
			busy <= 1'b0;
		end
	end

	assign owner = owner_q;

endmodule

`default_nettype wire

//--- src/axi_rd_pkg.sv
`default_nettype none

`include "axi_rd_settings.svh"

package axi_rd_pkg;

	// address request, 42 bits
	typedef struct packed {
		logic [`AXI_RD_ADDR_W-1:0] addr;
		logic [`AXI_RD_LEN_W-1:0]  len;   // beats minus one
		logic [1:0]                size;  // log2 of bytes per beat
	} ar_req_t;

	// one read beat, 99 bits
	typedef struct packed {
		logic [`AXI_RD_DATA_W-1:0] data;
		logic [`AXI_RD_ADDR_W-1:0] addr;  // byte address of this beat
		logic [1:0]                resp;
		logic                      last;
	} r_beat_t;

	// requester that holds the read channel
	typedef enum logic {
		own_fetch = 1'b0,
		own_mem   = 1'b1
	} owner_e;

	// backdoor preload write, one word
	typedef struct packed {
		logic [$clog2(`AXI_RD_MEM_WORDS)-1:0] addr;  // word index
		logic [`AXI_RD_DATA_W-1:0]            data;
	} mem_wr_t;

endpackage

`default_nettype wire

//--- src/axi_rd_settings.svh
`ifndef AXI_RD_SETTINGS_SVH
`define AXI_RD_SETTINGS_SVH

// byte address of a request or a beat
`define AXI_RD_ADDR_W 32

// one beat, also one memory word
`define AXI_RD_DATA_W 64

// burst length field, holds beats minus one
`define AXI_RD_LEN_W 8

// local memory depth in data words
`define AXI_RD_MEM_WORDS 256

// read response codes
`define AXI_RD_RESP_OKAY 2'd0
`define AXI_RD_RESP_SLVERR 2'd2

`endif
